//--- source/cl_shell_pkg.sv
/* Shared widths, response codes and card constants for the custom-logic shell.
   Host data is fixed at 32 bits with 4 byte strobes. */

package cl_shell_pkg;

  // --------------------------------------------------------------------------
  // Host AXI-Lite widths
  // --------------------------------------------------------------------------
  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
  localparam int RESP_W      = 2;

  // Only the two codes this slave ever returns
  typedef enum logic [RESP_W-1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } resp_e;

  // One access in flight at a time
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE_RESP,
    ST_READ_WAIT,
    ST_READ_RESP
  } bridge_state_e;

  // --------------------------------------------------------------------------
  // Status and counter widths
  // --------------------------------------------------------------------------
  localparam int STATUS_W  = 16;
  localparam int GLCOUNT_W = 64;

  // Card identification words
  // Vendor and device in ID0, subsystem in ID1
  localparam logic [31:0] CARD_ID0 = 32'hf000_1d0f;
  localparam logic [31:0] CARD_ID1 = 32'h1d51_fedd;

  // --------------------------------------------------------------------------
  // Top-level defaults
  // --------------------------------------------------------------------------
  // Must be a power of two, at least 2
  localparam int DEFAULT_MEM_WORDS = 256;

  localparam logic [STATUS_W-1:0] DEFAULT_VLED_PATTERN = 16'hbeef;

endpackage

//--- source/axil_channel_slice.sv
/* Single-entry register stage for one valid/ready channel.
   Adds one cycle of latency and still passes one item per cycle. */

`timescale 1ns/100ps

module axil_channel_slice #(
  parameter int WIDTH = 32
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  // Upstream side
  input  logic             s_valid_i,
  input  logic [WIDTH-1:0] s_data_i,
  output logic             s_ready_o,
  // Downstream side
  output logic             m_valid_o,
  output logic [WIDTH-1:0] m_data_o,
  input  logic             m_ready_i
);

  logic             full_q;
  logic [WIDTH-1:0] data_q;
  logic             take;

  // Room when empty or when the held item leaves this cycle
  assign s_ready_o = !full_q || m_ready_i;
  assign take      = s_valid_i && s_ready_o;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;
    end else if (m_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (take) begin
      data_q <= s_data_i;
    end
  end

  assign m_valid_o = full_q;
  assign m_data_o  = data_q;

  // Downstream sees a stable item until it is taken
  a_hold_stable: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o)
  );

endmodule

//--- source/axil_mem_bridge.sv
/* AXI-Lite slave onto a word memory, one access at a time and writes before reads.
   Addresses at or above 4*MEM_WORDS get SLVERR; sub-word address bits are ignored. */

`timescale 1ns/100ps

module axil_mem_bridge #(
  parameter int MEM_WORDS = 256
) (
  input  logic                                 clk_main_a0,
  input  logic                                 rst_main_n_sync,
  // Write address and data
  input  logic                                 awvalid_i,
  input  logic [cl_shell_pkg::AXIL_ADDR_W-1:0] awaddr_i,
  output logic                                 awready_o,
  input  logic                                 wvalid_i,
  input  logic [cl_shell_pkg::AXIL_DATA_W-1:0] wdata_i,
  input  logic [cl_shell_pkg::AXIL_STRB_W-1:0] wstrb_i,
  output logic                                 wready_o,
  // Write response
  output logic                                 bvalid_o,
  output cl_shell_pkg::resp_e                  bresp_o,
  input  logic                                 bready_i,
  // Read address
  input  logic                                 arvalid_i,
  input  logic [cl_shell_pkg::AXIL_ADDR_W-1:0] araddr_i,
  output logic                                 arready_o,
  // Read data
  output logic                                 rvalid_o,
  output logic [cl_shell_pkg::AXIL_DATA_W-1:0] rdata_o,
  output cl_shell_pkg::resp_e                  rresp_o,
  input  logic                                 rready_i,
  // Memory side
  output logic                                 mem_we_o,
  output logic                                 mem_re_o,
  output logic [$clog2(MEM_WORDS)-1:0]         mem_addr_o,
  output logic [cl_shell_pkg::AXIL_DATA_W-1:0] mem_wdata_o,
  output logic [cl_shell_pkg::AXIL_STRB_W-1:0] mem_wstrb_o,
  input  logic [cl_shell_pkg::AXIL_DATA_W-1:0] mem_rdata_i
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam logic [cl_shell_pkg::AXIL_ADDR_W-1:0] ADDR_LIMIT = 4 * MEM_WORDS;

  cl_shell_pkg::bridge_state_e state_q;

  cl_shell_pkg::resp_e                  bresp_q;
  cl_shell_pkg::resp_e                  rresp_q;
  logic [cl_shell_pkg::AXIL_DATA_W-1:0] rdata_q;
  logic                                 rd_ok_q;

  logic wr_go;
  logic rd_go;
  logic wr_in_range;
  logic rd_in_range;

  // --------------------------------------------------------------------------
  // Request acceptance
  // --------------------------------------------------------------------------
  // A write needs address and data together and wins over a waiting read
  assign wr_go = (state_q == cl_shell_pkg::ST_IDLE) && awvalid_i && wvalid_i;
  assign rd_go = (state_q == cl_shell_pkg::ST_IDLE) && arvalid_i && !(awvalid_i && wvalid_i);

  assign awready_o = wr_go;
  assign wready_o  = wr_go;
  assign arready_o = rd_go;

  assign wr_in_range = awaddr_i < ADDR_LIMIT;
  assign rd_in_range = araddr_i < ADDR_LIMIT;

  // Memory strobes only for in-range addresses
  assign mem_we_o    = wr_go && wr_in_range;
  assign mem_re_o    = rd_go && rd_in_range;
  assign mem_addr_o  = wr_go ? awaddr_i[IDX_W+1:2] : araddr_i[IDX_W+1:2];
  assign mem_wdata_o = wdata_i;
  assign mem_wstrb_o = wstrb_i;

  // --------------------------------------------------------------------------
  // Sequencing
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state_q <= cl_shell_pkg::ST_IDLE;
    end else begin
      case (state_q)
        cl_shell_pkg::ST_IDLE: begin
          if (wr_go) begin
            state_q <= cl_shell_pkg::ST_WRITE_RESP;
          end else if (rd_go) begin
            state_q <= cl_shell_pkg::ST_READ_WAIT;
          end
        end
        cl_shell_pkg::ST_WRITE_RESP: begin
          if (bready_i) begin
            state_q <= cl_shell_pkg::ST_IDLE;
          end
        end
        // Memory data arrives the cycle after mem_re
        cl_shell_pkg::ST_READ_WAIT: begin
          state_q <= cl_shell_pkg::ST_READ_RESP;
        end
        cl_shell_pkg::ST_READ_RESP: begin
          if (rready_i) begin
            state_q <= cl_shell_pkg::ST_IDLE;
          end
        end
        default: begin
          state_q <= cl_shell_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Response payload, held until the response slice takes it
  always_ff @(posedge clk_main_a0) begin
    if (wr_go) begin
      bresp_q <= wr_in_range ? cl_shell_pkg::RESP_OKAY : cl_shell_pkg::RESP_SLVERR;
    end
    if (rd_go) begin
      rresp_q <= rd_in_range ? cl_shell_pkg::RESP_OKAY : cl_shell_pkg::RESP_SLVERR;
      rd_ok_q <= rd_in_range;
    end
    if (state_q == cl_shell_pkg::ST_READ_WAIT) begin
      rdata_q <= rd_ok_q ? mem_rdata_i : '0;
    end
  end

  assign bvalid_o = (state_q == cl_shell_pkg::ST_WRITE_RESP);
  assign bresp_o  = bresp_q;
  assign rvalid_o = (state_q == cl_shell_pkg::ST_READ_RESP);
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;

  // Only one response channel active at a time
  a_one_resp: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(bvalid_o && rvalid_o)
  );

  // Address and data handshakes complete in the same cycle
  a_aw_w_pair: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $rose(awready_o) |-> $rose(wready_o) && awvalid_i && wvalid_i
  );

endmodule

//--- source/word_mem.sv
/* Word memory with per-byte write enables and a one-cycle registered read.
   No reset on the array, so unwritten words read back as unknown. */

`timescale 1ns/100ps

module word_mem #(
  parameter int MEM_WORDS = 256
) (
  input  logic                                 clk_main_a0,
  input  logic                                 we_i,
  input  logic                                 re_i,
  input  logic [$clog2(MEM_WORDS)-1:0]         addr_i,
  input  logic [cl_shell_pkg::AXIL_DATA_W-1:0] wdata_i,
  input  logic [cl_shell_pkg::AXIL_STRB_W-1:0] wstrb_i,
  output logic [cl_shell_pkg::AXIL_DATA_W-1:0] rdata_o
);

  logic [cl_shell_pkg::AXIL_DATA_W-1:0] mem [MEM_WORDS];
  logic [cl_shell_pkg::AXIL_DATA_W-1:0] rdata_q;

  // --------------------------------------------------------------------------
  // Byte-masked write
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (we_i) begin
      for (int b = 0; b < cl_shell_pkg::AXIL_STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Registered read, data valid the cycle after re_i
  always_ff @(posedge clk_main_a0) begin
    if (re_i) begin
      rdata_q <= mem[addr_i];
    end
  end

  assign rdata_o = rdata_q;

  // The bridge issues either a write or a read per cycle, never both.
  // Unknown strobes before reset settles are not counted as a collision
  a_no_rw_collide: assert property (
    @(posedge clk_main_a0)
    !(we_i === 1'b1 && re_i === 1'b1)
  );

endmodule

//--- source/status_regs.sv
/* Virtual DIP synchronizer, fixed LED pattern and global counter sample.
   Only the low 32 bits of the counter reach the status output. */

`timescale 1ns/100ps

module status_regs #(
  parameter logic [cl_shell_pkg::STATUS_W-1:0] VLED_PATTERN = 16'hbeef
) (
  input  logic                                clk_main_a0,
  input  logic                                rst_main_n_sync,
  input  logic [cl_shell_pkg::STATUS_W-1:0]   vdip_i,
  input  logic [cl_shell_pkg::GLCOUNT_W-1:0]  glcount_i,
  output logic [cl_shell_pkg::STATUS_W-1:0]   vled_o,
  output logic [31:0]                         status0_o,
  output logic [31:0]                         status1_o
);

  logic [cl_shell_pkg::STATUS_W-1:0] vdip_q1;
  logic [cl_shell_pkg::STATUS_W-1:0] vdip_q2;
  logic [cl_shell_pkg::STATUS_W-1:0] vled_q;
  logic [cl_shell_pkg::STATUS_W-1:0] vled_out_q;
  logic [31:0]                       glcount_q;

  // --------------------------------------------------------------------------
  // DIP synchronizer and LED register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1    <= '0;
      vdip_q2    <= '0;
      vled_q     <= '0;
      vled_out_q <= '0;
    end else begin
      vdip_q1    <= vdip_i;
      vdip_q2    <= vdip_q1;
      // Pattern reaches the pins on the second cycle out of reset
      vled_q     <= VLED_PATTERN;
      vled_out_q <= vled_q;
    end
  end

  // Counter sample, one cycle behind the shell counter
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      glcount_q <= '0;
    end else begin
      glcount_q <= glcount_i[31:0];
    end
  end

  assign vled_o    = vled_out_q;
  assign status0_o = {{(32 - cl_shell_pkg::STATUS_W){1'b0}}, vdip_q2};
  assign status1_o = glcount_q;

endmodule

//--- source/cl_shell_top.sv
/* Host-facing shell: AXI-Lite register slices into a word memory bridge, plus status.
   MEM_WORDS must be a power of two of at least 2. */

`timescale 1ns/100ps

module cl_shell_top #(
  parameter int MEM_WORDS = cl_shell_pkg::DEFAULT_MEM_WORDS,
  parameter logic [cl_shell_pkg::STATUS_W-1:0] VLED_PATTERN =
    cl_shell_pkg::DEFAULT_VLED_PATTERN
) (
  input  logic                                 clk_main_a0,
  input  logic                                 rst_main_n_sync,
  // Host AXI-Lite slave
  input  logic                                 sh_ocl_awvalid_i,
  input  logic [cl_shell_pkg::AXIL_ADDR_W-1:0] sh_ocl_awaddr_i,
  output logic                                 ocl_sh_awready_o,
  input  logic                                 sh_ocl_wvalid_i,
  input  logic [cl_shell_pkg::AXIL_DATA_W-1:0] sh_ocl_wdata_i,
  input  logic [cl_shell_pkg::AXIL_STRB_W-1:0] sh_ocl_wstrb_i,
  output logic                                 ocl_sh_wready_o,
  output logic                                 ocl_sh_bvalid_o,
  output logic [cl_shell_pkg::RESP_W-1:0]      ocl_sh_bresp_o,
  input  logic                                 sh_ocl_bready_i,
  input  logic                                 sh_ocl_arvalid_i,
  input  logic [cl_shell_pkg::AXIL_ADDR_W-1:0] sh_ocl_araddr_i,
  output logic                                 ocl_sh_arready_o,
  output logic                                 ocl_sh_rvalid_o,
  output logic [cl_shell_pkg::AXIL_DATA_W-1:0] ocl_sh_rdata_o,
  output logic [cl_shell_pkg::RESP_W-1:0]      ocl_sh_rresp_o,
  input  logic                                 sh_ocl_rready_i,
  // Status
  input  logic [cl_shell_pkg::STATUS_W-1:0]    sh_cl_status_vdip_i,
  input  logic [cl_shell_pkg::GLCOUNT_W-1:0]   sh_cl_glcount0_i,
  output logic [cl_shell_pkg::STATUS_W-1:0]    cl_sh_status_vled_o,
  output logic [31:0]                          cl_sh_status0_o,
  output logic [31:0]                          cl_sh_status1_o,
  // Card ID
  output logic [31:0]                          cl_sh_id0_o,
  output logic [31:0]                          cl_sh_id1_o
);

  localparam int ADDR_W = cl_shell_pkg::AXIL_ADDR_W;
  localparam int DATA_W = cl_shell_pkg::AXIL_DATA_W;
  localparam int STRB_W = cl_shell_pkg::AXIL_STRB_W;
  localparam int RESP_W = cl_shell_pkg::RESP_W;
  localparam int IDX_W  = $clog2(MEM_WORDS);

  // --------------------------------------------------------------------------
  // Bridge-side channel wires
  // --------------------------------------------------------------------------
  logic              aw_valid, aw_ready;
  logic [ADDR_W-1:0] aw_addr;
  logic              w_valid, w_ready;
  logic [DATA_W-1:0] w_data;
  logic [STRB_W-1:0] w_strb;
  logic              b_valid, b_ready;
  cl_shell_pkg::resp_e b_resp;
  logic              ar_valid, ar_ready;
  logic [ADDR_W-1:0] ar_addr;
  logic              r_valid, r_ready;
  logic [DATA_W-1:0] r_data;
  cl_shell_pkg::resp_e r_resp;

  // Memory strobes
  logic              mem_we, mem_re;
  logic [IDX_W-1:0]  mem_addr;
  logic [DATA_W-1:0] mem_wdata, mem_rdata;
  logic [STRB_W-1:0] mem_wstrb;

  // --------------------------------------------------------------------------
  // Register slices, requests inward and responses outward
  // --------------------------------------------------------------------------
  axil_channel_slice #(.WIDTH(ADDR_W)) aw_slice (
    .clk_main_a0, .rst_main_n_sync,
    .s_valid_i(sh_ocl_awvalid_i), .s_data_i(sh_ocl_awaddr_i), .s_ready_o(ocl_sh_awready_o),
    .m_valid_o(aw_valid), .m_data_o(aw_addr), .m_ready_i(aw_ready)
  );

  // Strobes ride above the data bits
  axil_channel_slice #(.WIDTH(STRB_W + DATA_W)) w_slice (
    .clk_main_a0, .rst_main_n_sync,
    .s_valid_i(sh_ocl_wvalid_i), .s_data_i({sh_ocl_wstrb_i, sh_ocl_wdata_i}),
    .s_ready_o(ocl_sh_wready_o),
    .m_valid_o(w_valid), .m_data_o({w_strb, w_data}), .m_ready_i(w_ready)
  );

  axil_channel_slice #(.WIDTH(RESP_W)) b_slice (
    .clk_main_a0, .rst_main_n_sync,
    .s_valid_i(b_valid), .s_data_i(b_resp), .s_ready_o(b_ready),
    .m_valid_o(ocl_sh_bvalid_o), .m_data_o(ocl_sh_bresp_o), .m_ready_i(sh_ocl_bready_i)
  );

  axil_channel_slice #(.WIDTH(ADDR_W)) ar_slice (
    .clk_main_a0, .rst_main_n_sync,
    .s_valid_i(sh_ocl_arvalid_i), .s_data_i(sh_ocl_araddr_i), .s_ready_o(ocl_sh_arready_o),
    .m_valid_o(ar_valid), .m_data_o(ar_addr), .m_ready_i(ar_ready)
  );

  axil_channel_slice #(.WIDTH(RESP_W + DATA_W)) r_slice (
    .clk_main_a0, .rst_main_n_sync,
    .s_valid_i(r_valid), .s_data_i({r_resp, r_data}), .s_ready_o(r_ready),
    .m_valid_o(ocl_sh_rvalid_o), .m_data_o({ocl_sh_rresp_o, ocl_sh_rdata_o}),
    .m_ready_i(sh_ocl_rready_i)
  );

  // --------------------------------------------------------------------------
  // Bridge and memory
  // --------------------------------------------------------------------------
  axil_mem_bridge #(.MEM_WORDS(MEM_WORDS)) bridge (
    .clk_main_a0, .rst_main_n_sync,
    .awvalid_i(aw_valid), .awaddr_i(aw_addr), .awready_o(aw_ready),
    .wvalid_i(w_valid), .wdata_i(w_data), .wstrb_i(w_strb), .wready_o(w_ready),
    .bvalid_o(b_valid), .bresp_o(b_resp), .bready_i(b_ready),
    .arvalid_i(ar_valid), .araddr_i(ar_addr), .arready_o(ar_ready),
    .rvalid_o(r_valid), .rdata_o(r_data), .rresp_o(r_resp), .rready_i(r_ready),
    .mem_we_o(mem_we), .mem_re_o(mem_re), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_wstrb_o(mem_wstrb), .mem_rdata_i(mem_rdata)
  );

  word_mem #(.MEM_WORDS(MEM_WORDS)) mem (
    .clk_main_a0,
    .we_i(mem_we), .re_i(mem_re), .addr_i(mem_addr),
    .wdata_i(mem_wdata), .wstrb_i(mem_wstrb), .rdata_o(mem_rdata)
  );

  // --------------------------------------------------------------------------
  // Status and ID
  // --------------------------------------------------------------------------
  status_regs #(.VLED_PATTERN(VLED_PATTERN)) status (
    .clk_main_a0, .rst_main_n_sync,
    .vdip_i(sh_cl_status_vdip_i), .glcount_i(sh_cl_glcount0_i),
    .vled_o(cl_sh_status_vled_o), .status0_o(cl_sh_status0_o), .status1_o(cl_sh_status1_o)
  );

  assign cl_sh_id0_o = cl_shell_pkg::CARD_ID0;
  assign cl_sh_id1_o = cl_shell_pkg::CARD_ID1;

endmodule

//--- include/tb_checks.svh
/* Compare task, error counters and the AXI-Lite host driver for the shell testbench.
   Included inside the testbench module, after the clock and host signals. */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int   error_count = 0;
logic test_failed = 1'b0;
int   seed        = 32'h1c0a_8dc0;

// Reports one mismatch and marks the running test as failed
task automatic check_value(input string what, input logic [63:0] actual,
                           input logic [63:0] expected);
  if (actual !== expected) begin
    $display("Fail at time %0t: %s is %h, expected %h", $time, what, actual, expected);
    error_count++;
    test_failed = 1'b1;
  end
endtask

// Response ready, high on about half of the cycles
function automatic logic random_bit();
  logic [31:0] r;
  r = $random(seed);
  return r[0];
endfunction

// ---------------------------------------------------------------------------
// One host transaction, ended by the response handshake on b or r
// ---------------------------------------------------------------------------
task automatic host_access(input logic is_write, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           output logic [31:0] rd_data, output logic [1:0] resp);
  logic done;
  done = 1'b0;
  @(posedge clk_main_a0);
  if (is_write) begin
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
  end else begin
    arvalid <= 1'b1;
    araddr  <= addr;
  end
  bready <= random_bit();
  rready <= random_bit();
  while (!done) begin
    @(posedge clk_main_a0);
    // Request valids drop on the edge where the slice takes them
    if (awvalid && awready) awvalid <= 1'b0;
    if (wvalid && wready) wvalid <= 1'b0;
    if (arvalid && arready) arvalid <= 1'b0;
    if ((bvalid && bready) || (rvalid && rready)) begin
      check_value("response channel is b", bvalid && bready, is_write);
      done    = 1'b1;
      rd_data = rdata;
      resp    = is_write ? bresp : rresp;
      bready <= 1'b0;
      rready <= 1'b0;
    end else begin
      bready <= random_bit();
      rready <= random_bit();
    end
  end
endtask

`endif

//--- test/tb_cl_shell.sv
/* Shell testbench, run from the project root so that the test file path resolves.
   Default DUT parameters, so byte addresses from 0x400 up are out of range. */

`timescale 1ns/100ps

module tb_cl_shell;

  localparam int          CLK_PERIOD      = 4;
  localparam int          CYCLES_PER_TEST = 200;
  localparam int          LINE_W          = 8 + 5 * 32;
  localparam logic [31:0] MEM_LIMIT       = 4 * cl_shell_pkg::DEFAULT_MEM_WORDS;
  localparam logic [15:0] INIT_VDIP       = 16'h5a5a;
  localparam logic [31:0] INIT_COUNT      = 32'h8000_0011;
  // Card identification words of this card
  localparam logic [31:0] EXPECT_ID0      = 32'hf000_1d0f;
  localparam logic [31:0] EXPECT_ID1      = 32'h1d51_fedd;

  logic        clk_main_a0;
  logic        rst_main_n_sync;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic [15:0] vdip, vled;
  logic [63:0] glcount;
  logic [31:0] status0, status1, id0, id1;

  // Test lines as {op, five columns}, and the memory words written so far
  logic [LINE_W-1:0] tests[$];
  logic [31:0]       shadow[int];
  int                test_total = 0;

  `include "tb_checks.svh"

  cl_shell_top uut (
    .clk_main_a0, .rst_main_n_sync,
    .sh_ocl_awvalid_i(awvalid), .sh_ocl_awaddr_i(awaddr), .ocl_sh_awready_o(awready),
    .sh_ocl_wvalid_i(wvalid), .sh_ocl_wdata_i(wdata), .sh_ocl_wstrb_i(wstrb),
    .ocl_sh_wready_o(wready),
    .ocl_sh_bvalid_o(bvalid), .ocl_sh_bresp_o(bresp), .sh_ocl_bready_i(bready),
    .sh_ocl_arvalid_i(arvalid), .sh_ocl_araddr_i(araddr), .ocl_sh_arready_o(arready),
    .ocl_sh_rvalid_o(rvalid), .ocl_sh_rdata_o(rdata), .ocl_sh_rresp_o(rresp),
    .sh_ocl_rready_i(rready),
    .sh_cl_status_vdip_i(vdip), .sh_cl_glcount0_i(glcount), .cl_sh_status_vled_o(vled),
    .cl_sh_status0_o(status0), .cl_sh_status1_o(status1),
    .cl_sh_id0_o(id0), .cl_sh_id1_o(id1)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_main_a0 = ~clk_main_a0;
  end

  // Watchdog, armed once the number of tests is known
  initial begin
    wait (test_total > 0);
    #(CLK_PERIOD * CYCLES_PER_TEST * test_total);
    $display("Timeout: the tests did not complete within %0d cycles",
             CYCLES_PER_TEST * test_total);
    $display("Finished with errors");
    $finish;
  end

  // Every line that is not a comment becomes one test
  task automatic load_tests();
    int          fd;
    int          code;
    string       line;
    logic [7:0]  op;
    logic [31:0] a, b, c, d, e;
    fd = $fopen("test/cl_shell_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open test/cl_shell_tests.txt, so no tests were run");
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        code = $sscanf(line, "%c %h %h %h %h %h", op, a, b, c, d, e);
        if (code == 6 && op != "#") begin
          tests.push_back({op, a, b, c, d, e});
        end
      end
      $fclose(fd);
    end
    test_total = tests.size() + 1;
  endtask

  initial begin
    logic [7:0]  op;
    logic [31:0] a, b, c, d, e;
    logic [31:0] data;
    logic [31:0] prev0;
    logic [31:0] prev1;
    logic [1:0]  resp;
    int          word;
    rst_main_n_sync = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    vdip    = INIT_VDIP;
    glcount = {~INIT_COUNT, INIT_COUNT};
    prev0   = {16'h0000, INIT_VDIP};
    prev1   = INIT_COUNT;
    load_tests();

    // Reset low for four edges, status checked on the last three of them
    @(posedge clk_main_a0);
    repeat (3) begin
      @(posedge clk_main_a0);
      check_value("vled in reset", vled, 0);
      check_value("status0 in reset", status0, 0);
      check_value("status1 in reset", status1, 0);
    end
    rst_main_n_sync <= 1'b1;
    repeat (3) @(posedge clk_main_a0);
    check_value("vled after reset", vled, 16'hbeef);
    check_value("id0", id0, EXPECT_ID0);
    check_value("id1", id1, EXPECT_ID1);
    $display("Test 0 reset: %s", test_failed ? "FAILED" : "ok");

    foreach (tests[i]) begin
      {op, a, b, c, d, e} = tests[i];
      test_failed = 1'b0;
      word = a >> 2;
      case (op)
        "W": begin
          host_access(1'b1, a, b, c[3:0], data, resp);
          check_value("bresp", resp, d);
          // Only the strobed bytes of the tracked word change
          if (a < MEM_LIMIT) begin
            data = shadow.exists(word) ? shadow[word] : '0;
            for (int k = 0; k < 4; k++) begin
              if (c[k]) data[8*k +: 8] = b[8*k +: 8];
            end
            shadow[word] = data;
          end
        end
        "R": begin
          host_access(1'b0, a, 32'h0, 4'h0, data, resp);
          check_value("rresp", resp, d);
          check_value("rdata", data, e);
          if (a < MEM_LIMIT && shadow.exists(word)) begin
            check_value("rdata against tracked memory", data, shadow[word]);
          end
        end
        "D": begin
          @(posedge clk_main_a0);
          vdip    <= a[15:0];
          glcount <= {~b, b};
          // Counter sample lags by one edge, the DIP synchronizer by two
          @(posedge clk_main_a0);
          check_value("status1 before update", status1, prev1);
          @(posedge clk_main_a0);
          check_value("status1", status1, d);
          check_value("status0 before update", status0, prev0);
          @(posedge clk_main_a0);
          check_value("status0", status0, e);
          prev0 = e;
          prev1 = d;
        end
        default: begin
          $display("Test %0d has an unknown operation %c", i + 1, op);
          error_count++;
          test_failed = 1'b1;
        end
      endcase
      $display("Test %0d %c %h: %s", i + 1, op, a, test_failed ? "FAILED" : "ok");
    end

    $display("Tests run: %0d, errors: %0d", test_total, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- test/cl_shell_tests.txt
# op addr/vdip data/count strobes resp/status1 rdata/status0, all hex
# W write, R read, D set DIP and counter then check status; unused fields are 0
W 00000000 11223344 f 0 00000000
R 00000000 00000000 0 0 11223344
W 00000010 a5a5a5a5 f 0 00000000
W 00000010 0000cc00 2 0 00000000
W 00000010 77000000 8 0 00000000
R 00000010 00000000 0 0 77a5cca5
W 00000400 deadbeef f 2 00000000
R 00000400 00000000 0 2 00000000
R 00000000 00000000 0 0 11223344
W 000003fc cafef00d f 0 00000000
R 000003fc 00000000 0 0 cafef00d
R 80000000 00000000 0 2 00000000
W 00000020 01010101 f 0 00000000
W 00000020 000000ee 1 0 00000000
R 00000020 00000000 0 0 010101ee
R 000003fc 00000000 0 0 cafef00d
D 00001234 0badf00d 0 0badf00d 00001234
D 0000ffff 00000001 0 00000001 0000ffff

//--- filelist.f
+incdir+include
source/cl_shell_pkg.sv
source/axil_channel_slice.sv
source/axil_mem_bridge.sv
source/word_mem.sv
source/status_regs.sv
source/cl_shell_top.sv
test/tb_cl_shell.sv
